// File: filelist.f
+incdir+rtl
rtl/switch_pkg.sv
rtl/packet_writer.sv
rtl/page_free_list.sv
rtl/page_buffer.sv
rtl/output_queues.sv
rtl/packet_reader.sv
rtl/switch_top.sv
sim/switch_checker.sv
sim/switch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the switch testbench with Verilator and run it once.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module switch_tb -o switch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/switch_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// File: sim/switch_tb.sv
`include "switch_config.svh"

module switch_tb import switch_pkg::*; ();

    // 64 packets at up to 40 cycles each, plus time to drain.
    localparam int TIMEOUT_CYCLES = 64 * 40 + 800;

    logic                  clk;
    logic                  rst_n;
    logic [`SW_PORTS-1:0]  wr_sop;
    logic [`SW_PORTS-1:0]  wr_eop;
    logic [`SW_PORTS-1:0]  wr_vld;
    word_t [`SW_PORTS-1:0] wr_data;
    logic [`SW_PORTS-1:0]  pause;
    logic                  full;
    logic [`SW_PORTS-1:0]  ready;
    logic [`SW_PORTS-1:0]  rd_sop;
    logic [`SW_PORTS-1:0]  rd_eop;
    logic [`SW_PORTS-1:0]  rd_vld;
    word_t [`SW_PORTS-1:0] rd_data;

    // expected words per dest and priority, whole packets back to back.
    word_t exp_q [`SW_PORTS][`SW_PRIOS][$];
    prio_t cur_prio [`SW_PORTS];
    int    left [`SW_PORTS];
    prio_t order_log [$];
    prio_t sent [$];
    bit    log_en;
    int    pending;
    int    value_errs;
    int    other_errs;
    int    cycles;

    switch_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_port(input string name, input port_t got, input port_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_prio(input string name, input prio_t got, input prio_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // offers the header until the port is granted, then streams the rest.
    task automatic send_packet(input port_t src, input port_t dest, input prio_t prio,
                               input int len);
        word_t words [$];
        logic  accepted;
        words.push_back(word_t'({7'($urandom), len[4:0], prio, dest}));
        for (int i = 1; i < len; i++) begin
            words.push_back(word_t'($urandom));
        end
        @(posedge clk);
        wr_sop[src]  <= 1'b1;
        wr_vld[src]  <= 1'b1;
        wr_eop[src]  <= 1'b0;
        wr_data[src] <= words[0];
        do begin
            @(negedge clk);
            accepted = !pause[src];
            @(posedge clk);
        end while (!accepted);
        foreach (words[i]) begin
            exp_q[dest][prio].push_back(words[i]);
        end
        pending++;
        wr_sop[src] <= 1'b0;
        for (int i = 1; i < len; i++) begin
            wr_data[src] <= words[i];
            wr_eop[src]  <= (i == len - 1);
            @(posedge clk);
        end
        wr_vld[src] <= 1'b0;
        wr_eop[src] <= 1'b0;
    endtask

    task automatic drain();
        while (pending != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    // output side model check, the expected header gives the length.
    always @(negedge clk) begin
        word_t exp_hdr;
        for (int p = 0; p < `SW_PORTS; p++) begin
            if (rst_n && rd_vld[p]) begin
                check_bit("rd_sop", rd_sop[p], left[p] == 0);
                if (left[p] == 0) begin
                    cur_prio[p] = prio_t'(rd_data[p][3:2]);
                    check_port("rd_data.dest", port_t'(rd_data[p][1:0]), port_t'(p));
                    left[p] = 1;
                    if (exp_q[p][cur_prio[p]].size() != 0) begin
                        exp_hdr = exp_q[p][cur_prio[p]][0];
                        left[p] = (exp_hdr[8:4] == 5'd0) ? `SW_MAX_WORDS
                                                         : int'(exp_hdr[8:4]);
                    end
                    if (log_en && p == 0) begin
                        order_log.push_back(cur_prio[p]);
                    end
                end
                if (exp_q[p][cur_prio[p]].size() == 0) begin
                    $display("word on output port %0d while no packet was expected", p);
                    other_errs++;
                end else begin
                    check_word("rd_data", rd_data[p], exp_q[p][cur_prio[p]].pop_front());
                end
                left[p]--;
                check_bit("rd_eop", rd_eop[p], left[p] == 0);
                if (rd_eop[p]) begin
                    pending--;
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles, traffic did not drain", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h7c2c));
        rst_n   = 1'b0;
        wr_sop  = '0;
        wr_eop  = '0;
        wr_vld  = '0;
        wr_data = '0;
        ready   = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        ready <= '1;

        // random traffic, every port draining.
        repeat (40) begin
            send_packet(port_t'($urandom), port_t'($urandom), prio_t'($urandom),
                        $urandom_range(`SW_MAX_WORDS, 2));
        end
        drain();

        // port 0 held back, then released with mixed priorities queued.
        @(posedge clk);
        ready  <= {{(`SW_PORTS-1){1'b1}}, 1'b0};
        log_en = 1'b1;
        repeat (8) begin
            sent.push_back(prio_t'($urandom));
            send_packet(port_t'($urandom), port_t'(0), sent[$], $urandom_range(16, 2));
        end
        repeat (4) @(posedge clk);
        ready <= '1;
        drain();
        log_en = 1'b0;
        if (order_log.size() != sent.size()) begin
            $display("port 0 sent %0d packets in the priority test instead of %0d",
                     order_log.size(), sent.size());
            other_errs++;
        end else begin
            sent.rsort();
            foreach (sent[i]) begin
                check_prio("rd_data.prio", order_log[i], sent[i]);
            end
        end

        // fill the buffer with nothing leaving.
        @(posedge clk);
        ready <= '0;
        repeat (8) begin
            send_packet(port_t'($urandom), port_t'($urandom), prio_t'($urandom),
                        `SW_MAX_WORDS);
        end
        @(negedge clk);
        check_bit("full", full, 1'b1);
        repeat (8) begin
            @(negedge clk);
            check_bit("pause", &pause, 1'b1);
        end
        @(posedge clk);
        ready <= '1;
        drain();
        @(negedge clk);
        check_bit("full", full, 1'b0);

        // every page must be back for a burst of maximum packets.
        repeat (8) begin
            send_packet(port_t'($urandom), port_t'($urandom), prio_t'($urandom),
                        `SW_MAX_WORDS);
        end
        drain();
        @(negedge clk);
        check_bit("full", full, 1'b0);

        for (int d = 0; d < `SW_PORTS; d++) begin
            for (int q = 0; q < `SW_PRIOS; q++) begin
                if (exp_q[d][q].size() != 0) begin
                    $display("%0d words for port %0d priority %0d never left the switch",
                             exp_q[d][q].size(), d, q);
                    other_errs++;
                end
            end
        end
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sim/switch_checker.sv
`include "switch_config.svh"

module switch_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic [`SW_PORTS-1:0] pause,
    input logic                 full,
    input logic [`SW_PORTS-1:0] rd_sop,
    input logic [`SW_PORTS-1:0] rd_eop,
    input logic [`SW_PORTS-1:0] rd_vld
);

    // reset was seen at the previous edge.
    logic in_reset_q;

    always_ff @(posedge clk) begin
        in_reset_q <= !rst_n;
    end

    // no gap between sop and eop.
    a_vld_gapless: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rd_vld & ~rd_eop) & ~rd_vld) == '0)
        else $error("rd_vld dropped inside a packet");

    // a packet opens only with sop.
    a_vld_start: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld & ~rd_sop & ~$past(rd_vld & ~rd_eop)) == '0)
        else $error("rd_vld began without rd_sop");

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $countones(~pause) <= 1)
        else $error("more than one pause bit low");

    a_full_pause: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> (pause == '1))
        else $error("a port was open while the buffer was full");

    a_reset_out: assert property (@(posedge clk)
        (in_reset_q && !rst_n) |->
            (pause == '1 && !full && rd_sop == '0 && rd_eop == '0 && rd_vld == '0))
        else $error("outputs left their reset values during reset");

endmodule

bind switch_top switch_checker switch_top_bind (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .full(full),
    .rd_sop(rd_sop),
    .rd_eop(rd_eop),
    .rd_vld(rd_vld)
);

// File: rtl/switch_top.sv
`include "switch_config.svh"

module switch_top import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_PORTS-1:0]  wr_sop,
    input  logic [`SW_PORTS-1:0]  wr_eop,
    input  logic [`SW_PORTS-1:0]  wr_vld,
    input  word_t [`SW_PORTS-1:0] wr_data,
    output logic [`SW_PORTS-1:0]  pause,
    output logic                  full,
    input  logic [`SW_PORTS-1:0]  ready,
    output logic [`SW_PORTS-1:0]  rd_sop,
    output logic [`SW_PORTS-1:0]  rd_eop,
    output logic [`SW_PORTS-1:0]  rd_vld,
    output word_t [`SW_PORTS-1:0] rd_data
);

    logic                 alloc;
    page_t                free_page;
    buf_wr_t              buf_wr;
    enq_req_t             enq;
    logic                 deq;
    port_t                deq_port;
    page_t                head_page;
    logic [`SW_PORTS-1:0] nonempty;
    buf_addr_t            rd_addr;
    word_t                rd_word;
    page_t                rd_next;
    logic                 release_en;
    page_t                release_page;

    packet_writer u_writer (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .full(full), .pause(pause),
        .alloc(alloc), .free_page(free_page),
        .buf_wr(buf_wr), .enq(enq)
    );

    page_free_list u_free_list (
        .clk(clk), .rst_n(rst_n),
        .alloc(alloc), .release_en(release_en), .release_page(release_page),
        .free_page(free_page), .full(full)
    );

    page_buffer u_buffer (
        .clk(clk), .buf_wr(buf_wr),
        .rd_addr(rd_addr), .rd_word(rd_word), .rd_next(rd_next)
    );

    output_queues u_queues (
        .clk(clk), .rst_n(rst_n), .enq(enq),
        .deq(deq), .deq_port(deq_port),
        .nonempty(nonempty), .head_page(head_page)
    );

    packet_reader u_reader (
        .clk(clk), .rst_n(rst_n),
        .ready(ready), .nonempty(nonempty),
        .deq(deq), .deq_port(deq_port), .head_page(head_page),
        .rd_addr(rd_addr), .rd_word(rd_word), .rd_next(rd_next),
        .release_en(release_en), .release_page(release_page),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data)
    );

endmodule

// File: rtl/packet_reader.sv
`include "switch_config.svh"

module packet_reader import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_PORTS-1:0]  ready,
    input  logic [`SW_PORTS-1:0]  nonempty,
    output logic                  deq,
    output port_t                 deq_port,
    input  page_t                 head_page,
    output buf_addr_t             rd_addr,
    input  word_t                 rd_word,
    input  page_t                 rd_next,
    output logic                  release_en,
    output page_t                 release_page,
    output logic [`SW_PORTS-1:0]  rd_sop,
    output logic [`SW_PORTS-1:0]  rd_eop,
    output logic [`SW_PORTS-1:0]  rd_vld,
    output word_t [`SW_PORTS-1:0] rd_data
);

    port_t                scan;
    port_t                out_port;
    logic                 hdr_q;
    len_t                 cnt_q;
    len_t                 pkt_len;
    len_t                 rem;
    page_t                a_page;
    off_t                 a_off;
    logic                 active;
    logic                 fetch;
    logic                 page_done;
    hdr_word_u            hdr;
    logic [`SW_PORTS-1:0] out_mask;

    assign hdr     = rd_word;
    assign pkt_len = (hdr.hdr.length == '0) ? len_t'(`SW_MAX_WORDS) : len_t'(hdr.hdr.length);

    // a word arrives from the buffer in every active cycle.
    assign active = hdr_q || (cnt_q != '0);

    // words still due after the one arriving now.
    always_comb begin
        if (hdr_q) begin
            rem = pkt_len - 1'b1;
        end else if (cnt_q != '0) begin
            rem = cnt_q - 1'b1;
        end else begin
            rem = '0;
        end
    end

    assign deq       = !active && ready[scan] && nonempty[scan];
    assign deq_port  = scan;
    assign fetch     = active && (rem != '0);
    assign page_done = fetch && ((a_off == off_t'(`SW_PAGE_WORDS - 1)) || (rem == len_t'(1)));

    always_comb begin
        if (deq) begin
            rd_addr.page   = head_page;
            rd_addr.offset = '0;
        end else begin
            rd_addr.page   = a_page;
            rd_addr.offset = a_off;
        end
    end

    always_comb begin
        out_mask = '0;
        out_mask[out_port] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan       <= '0;
            hdr_q      <= 1'b0;
            cnt_q      <= '0;
            release_en <= 1'b0;
            rd_sop     <= '0;
            rd_eop     <= '0;
            rd_vld     <= '0;
        end else begin
            if (!active) begin
                scan <= scan + 1'b1;
            end
            hdr_q      <= deq;
            cnt_q      <= rem;
            // a header-only packet frees its page once the length is known.
            release_en <= page_done || (hdr_q && (rem == '0));
            rd_sop     <= hdr_q ? out_mask : '0;
            rd_vld     <= active ? out_mask : '0;
            rd_eop     <= (active && (rem == '0)) ? out_mask : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (deq) begin
            out_port <= scan;
            a_page   <= head_page;
            a_off    <= off_t'(1);
        end else if (fetch) begin
            a_off <= a_off + 1'b1;
            // the link of this page was read along with offset 6.
            if (a_off == off_t'(`SW_PAGE_WORDS - 1)) begin
                a_page <= rd_next;
            end
        end
        release_page <= a_page;
        if (active) begin
            rd_data[out_port] <= rd_word;
        end
    end

endmodule

// File: rtl/output_queues.sv
`include "switch_config.svh"

module output_queues import switch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  enq_req_t             enq,
    input  logic                 deq,
    input  port_t                deq_port,
    output logic [`SW_PORTS-1:0] nonempty,
    output page_t                head_page
);

    // one head-page FIFO per output and priority.
    page_t                heads  [`SW_PORTS][`SW_PRIOS][`SW_PAGES];
    qptr_t                wr_ptr [`SW_PORTS][`SW_PRIOS];
    qptr_t                rd_ptr [`SW_PORTS][`SW_PRIOS];
    logic [`SW_PRIOS-1:0] filled [`SW_PORTS];
    prio_t                sel_prio;

    always_comb begin
        for (int p = 0; p < `SW_PORTS; p++) begin
            for (int q = 0; q < `SW_PRIOS; q++) begin
                filled[p][q] = wr_ptr[p][q] != rd_ptr[p][q];
            end
            nonempty[p] = |filled[p];
        end
    end

    // strict priority, the highest filled queue wins.
    always_comb begin
        sel_prio = '0;
        for (int q = 0; q < `SW_PRIOS; q++) begin
            if (filled[deq_port][q]) begin
                sel_prio = prio_t'(q);
            end
        end
    end

    assign head_page = heads[deq_port][sel_prio][page_t'(rd_ptr[deq_port][sel_prio])];

    always_ff @(posedge clk) begin
        if (enq.valid) begin
            heads[enq.dest][enq.prio][page_t'(wr_ptr[enq.dest][enq.prio])] <= enq.head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `SW_PORTS; p++) begin
                for (int q = 0; q < `SW_PRIOS; q++) begin
                    wr_ptr[p][q] <= '0;
                    rd_ptr[p][q] <= '0;
                end
            end
        end else begin
            if (enq.valid) begin
                wr_ptr[enq.dest][enq.prio] <= wr_ptr[enq.dest][enq.prio] + 1'b1;
            end
            if (deq) begin
                rd_ptr[deq_port][sel_prio] <= rd_ptr[deq_port][sel_prio] + 1'b1;
            end
        end
    end

endmodule

// File: rtl/page_buffer.sv
`include "switch_config.svh"

module page_buffer import switch_pkg::*; (
    input  logic      clk,
    input  buf_wr_t   buf_wr,
    input  buf_addr_t rd_addr,
    output word_t     rd_word,
    output page_t     rd_next
);

    // words are addressed by page and offset within the page.
    word_t words [`SW_PAGES * `SW_PAGE_WORDS];
    page_t links [`SW_PAGES];

    always_ff @(posedge clk) begin
        if (buf_wr.en) begin
            words[{buf_wr.page, buf_wr.offset}] <= buf_wr.data;
        end
        if (buf_wr.link_en) begin
            links[buf_wr.page] <= buf_wr.link_page;
        end
    end

    // registered read, the link comes with the word.
    always_ff @(posedge clk) begin
        rd_word <= words[{rd_addr.page, rd_addr.offset}];
        rd_next <= links[rd_addr.page];
    end

endmodule

// File: rtl/page_free_list.sv
`include "switch_config.svh"

module page_free_list import switch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  alloc,
    input  logic  release_en,
    input  page_t release_page,
    output page_t free_page,
    output logic  full
);

    page_t pages [`SW_PAGES];
    page_t rd_ptr;
    page_t wr_ptr;
    cnt_t  free_cnt;

    assign free_page = pages[rd_ptr];

    // too few pages left for a maximum packet.
    assign full = free_cnt < cnt_t'(`SW_FULL_PAGES);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            free_cnt <= cnt_t'(`SW_PAGES);
            for (int i = 0; i < `SW_PAGES; i++) begin
                pages[i] <= page_t'(i);
            end
        end else begin
            if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_en) begin
                pages[wr_ptr] <= release_page;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            case ({alloc, release_en})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

endmodule

// File: rtl/packet_writer.sv
`include "switch_config.svh"

module packet_writer import switch_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_PORTS-1:0]  wr_sop,
    input  logic [`SW_PORTS-1:0]  wr_eop,
    input  logic [`SW_PORTS-1:0]  wr_vld,
    input  word_t [`SW_PORTS-1:0] wr_data,
    input  logic                  full,
    output logic [`SW_PORTS-1:0]  pause,
    output logic                  alloc,
    input  page_t                 free_page,
    output buf_wr_t               buf_wr,
    output enq_req_t              enq
);

    port_t                grant;
    logic                 open_q;
    logic                 busy_q;
    off_t                 offset;
    page_t                cur_page;
    page_t                head_page;
    port_t                dest;
    prio_t                prio;
    logic                 enq_valid;
    hdr_word_u            first;
    logic [`SW_PORTS-1:0] grant_mask;
    logic                 start;
    logic                 fire;
    logic                 last;

    assign first = wr_data[grant];
    assign start = open_q && !full && wr_sop[grant] && wr_vld[grant];
    assign fire  = start || (busy_q && wr_vld[grant]);
    assign last  = fire && wr_eop[grant];

    always_comb begin
        grant_mask = '0;
        grant_mask[grant] = 1'b1;
    end

    // only the granted port may open a packet, and only while pages remain.
    assign pause = (open_q && !full) ? ~grant_mask : '1;

    // a new page is taken whenever a word lands at offset 0.
    assign alloc = fire && (offset == '0);

    always_comb begin
        buf_wr.en        = fire;
        buf_wr.page      = (offset == '0) ? free_page : cur_page;
        buf_wr.offset    = offset;
        buf_wr.data      = wr_data[grant];
        // the head of the free list is the page taken on the next cycle.
        buf_wr.link_en   = fire && !wr_eop[grant] && (offset == off_t'(`SW_PAGE_WORDS - 1));
        buf_wr.link_page = free_page;
    end

    always_comb begin
        enq.valid = enq_valid;
        enq.dest  = dest;
        enq.prio  = prio;
        enq.head  = head_page;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant     <= '0;
            open_q    <= 1'b0;
            busy_q    <= 1'b0;
            offset    <= '0;
            enq_valid <= 1'b0;
        end else begin
            enq_valid <= last;
            if (last) begin
                open_q <= 1'b1;
                busy_q <= 1'b0;
                grant  <= grant + 1'b1;
            end else if (start) begin
                open_q <= 1'b0;
                busy_q <= 1'b1;
            end else if (open_q) begin
                grant <= grant + 1'b1;
            end else if (!busy_q) begin
                open_q <= 1'b1;
            end
            if (fire) begin
                offset <= last ? '0 : offset + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            head_page <= free_page;
            dest      <= first.hdr.dest;
            prio      <= first.hdr.prio;
        end
        if (alloc) begin
            cur_page <= free_page;
        end
    end

endmodule

// File: rtl/switch_pkg.sv
`include "switch_config.svh"

package switch_pkg;

    typedef logic [$clog2(`SW_PORTS)-1:0]       port_t;
    typedef logic [$clog2(`SW_PRIOS)-1:0]       prio_t;
    typedef logic [$clog2(`SW_PAGES)-1:0]       page_t;
    typedef logic [$clog2(`SW_PAGE_WORDS)-1:0]  off_t;
    typedef logic [15:0]                        word_t;
    // free page count, reaches SW_PAGES.
    typedef logic [$clog2(`SW_PAGES+1)-1:0]     cnt_t;
    // word count of one packet, reaches SW_MAX_WORDS.
    typedef logic [$clog2(`SW_MAX_WORDS+1)-1:0] len_t;
    // queue pointer with one wrap bit.
    typedef logic [$clog2(`SW_PAGES):0]         qptr_t;

    // first word of a packet, length 0 stands for the maximum.
    typedef struct packed {
        logic [6:0]                          spare;
        logic [$clog2(`SW_MAX_WORDS)-1:0]    length;
        prio_t                               prio;
        port_t                               dest;
    } hdr_t;

    typedef union packed {
        word_t word;
        hdr_t  hdr;
    } hdr_word_u;

    typedef struct packed {
        logic  en;
        page_t page;
        off_t  offset;
        word_t data;
        logic  link_en;
        page_t link_page;
    } buf_wr_t;

    typedef struct packed {
        page_t page;
        off_t  offset;
    } buf_addr_t;

    typedef struct packed {
        logic  valid;
        port_t dest;
        prio_t prio;
        page_t head;
    } enq_req_t;

endpackage

// File: rtl/switch_config.svh
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// number of input and output ports.
`define SW_PORTS 4

// priorities per output, larger value wins.
`define SW_PRIOS 4

// 16-bit words held by one page.
`define SW_PAGE_WORDS 8

// pages in the shared buffer.
`define SW_PAGES 32

// longest packet in words, header included.
`define SW_MAX_WORDS 32

// free pages needed to admit one more maximum packet.
`define SW_FULL_PAGES 4

`endif
